//--- source/i2c_bus_pkg.sv
`default_nettype none

package i2c_bus_pkg;

    localparam int PRESCALE_W   = 16;  // prescale value width
    localparam int FILTER_CNT_W = 14;  // filter sub-sample counter width
    localparam int FILTER_TAPS  = 3;   // majority window length

    typedef enum logic [2:0] {
        CMD_NONE  = 3'b000,  // illegal, ignored by the sequencer
        CMD_START = 3'b001,
        CMD_STOP  = 3'b010,
        CMD_WRITE = 3'b011,
        CMD_READ  = 3'b100,
        CMD_WAIT  = 3'b101
    } bus_cmd_e;

    typedef logic [1:0] phase_t;  // bus phase 0..3

    typedef struct packed {
        logic scl;
        logic sda;
    } line_pair_t;

    typedef struct packed {
        line_pair_t cur;   // filtered levels
        line_pair_t prev;  // same levels, one cycle later
    } filt_lines_t;

    // line enables per command and phase, 1 = released, 0 = pulled low
    function automatic line_pair_t phase_levels(input bus_cmd_e cmd, input phase_t ph,
                                                input logic scl_oen, input logic wr_bit);
        line_pair_t lv;
        logic       scl_pulse;
        scl_pulse = (ph == 2'd1) || (ph == 2'd2);  // data clock high in middle phases
        case (cmd)
            CMD_START: lv = (ph == 2'd0) ? '{scl: scl_oen, sda: 1'b1} :
                            (ph == 2'd1) ? '{scl: 1'b1, sda: 1'b1} :
                            (ph == 2'd2) ? '{scl: 1'b1, sda: 1'b0} : '{scl: 1'b0, sda: 1'b0};
            CMD_STOP:  lv = (ph == 2'd0) ? '{scl: 1'b0, sda: 1'b0} :
                            (ph == 2'd3) ? '{scl: 1'b1, sda: 1'b1} : '{scl: 1'b1, sda: 1'b0};
            CMD_READ:  lv = '{scl: scl_pulse, sda: 1'b1};    // SDA left to the slave
            CMD_WRITE: lv = '{scl: scl_pulse, sda: wr_bit};  // SDA held for whole bit
            default:   lv = '{scl: 1'b1, sda: 1'b1};         // WAIT, both released
        endcase
        return lv;
    endfunction

endpackage

`default_nettype wire

//--- source/i2c_line_filter.sv
`timescale 1ns/1ns
`default_nettype none

module i2c_line_filter
    import i2c_bus_pkg::*;
(
    input  logic                  clk_i,      // system clock
    input  logic                  rstn_i,     // async reset, active low
    input  logic                  sw_rst_i,   // software abort
    input  logic [PRESCALE_W-1:0] clk_cnt_i,  // prescale value
    input  line_pair_t            lines_i,    // raw bus levels
    output filt_lines_t           filt_o      // filtered levels and delayed copy
);

    line_pair_t              sync_q1;    // first synchronizer stage
    line_pair_t              sync_q2;    // second synchronizer stage
    logic [FILTER_CNT_W-1:0] sub_cnt_q;  // sub-sample divider
    logic [FILTER_TAPS-1:0]  win_scl_q;  // SCL sample window
    logic [FILTER_TAPS-1:0]  win_sda_q;  // SDA sample window
    logic                    sample_en;
    line_pair_t              vote;

    // two out of three
    function automatic logic majority(input logic [FILTER_TAPS-1:0] w);
        return (w[2] & w[1]) | (w[1] & w[0]) | (w[2] & w[0]);
    endfunction

    assign sample_en = (sub_cnt_q == '0);  // one sample per divider wrap
    assign vote.scl  = majority(win_scl_q);
    assign vote.sda  = majority(win_sda_q);

    always_ff @(posedge clk_i or negedge rstn_i)
    begin
        if (!rstn_i)
        begin
            sync_q1 <= '1;  // idle bus reads high
            sync_q2 <= '1;
        end
        else if (sw_rst_i)
        begin
            sync_q1 <= '1;
            sync_q2 <= '1;
        end
        else
        begin
            sync_q1 <= lines_i;
            sync_q2 <= sync_q1;
        end
    end

    // samples at roughly 16x the bus rate
    always_ff @(posedge clk_i or negedge rstn_i)
    begin
        if (!rstn_i)
            sub_cnt_q <= '0;
        else if (sw_rst_i || sample_en)
            sub_cnt_q <= sw_rst_i ? '0 : FILTER_CNT_W'(clk_cnt_i >> 2);  // truncated reload
        else
            sub_cnt_q <= sub_cnt_q - 1'b1;
    end

    always_ff @(posedge clk_i or negedge rstn_i)
    begin
        if (!rstn_i)
        begin
            win_scl_q <= '1;
            win_sda_q <= '1;
            filt_o    <= '1;
        end
        else if (sw_rst_i)
        begin
            win_scl_q <= '1;
            win_sda_q <= '1;
            filt_o    <= '1;
        end
        else
        begin
            if (sample_en)
            begin
                win_scl_q <= {win_scl_q[FILTER_TAPS-2:0], sync_q2.scl};  // shift in new sample
                win_sda_q <= {win_sda_q[FILTER_TAPS-2:0], sync_q2.sda};
            end
            filt_o.cur  <= vote;        // vote cycle
            filt_o.prev <= filt_o.cur;  // one cycle behind cur
        end
    end

endmodule

`default_nettype wire

//--- source/i2c_bus_monitor.sv
`timescale 1ns/1ns
`default_nettype none

module i2c_bus_monitor
    import i2c_bus_pkg::*;
(
    input  logic        clk_i,     // system clock
    input  logic        rstn_i,    // async reset, active low
    input  logic        sw_rst_i,  // software abort
    input  filt_lines_t filt_i,    // filtered lines
    output logic        busy_o,    // bus busy between START and STOP
    output logic        dout_o     // last bit seen on SCL rise
);

    logic start_q;  // START strobe
    logic stop_q;   // STOP strobe
    logic scl_rise;

    assign scl_rise = filt_i.cur.scl & ~filt_i.prev.scl;

    always_ff @(posedge clk_i or negedge rstn_i)
    begin
        if (!rstn_i)
        begin
            start_q <= 1'b0;
            stop_q  <= 1'b0;
            busy_o  <= 1'b0;
        end
        else if (sw_rst_i)
        begin
            start_q <= 1'b0;
            stop_q  <= 1'b0;
            busy_o  <= 1'b0;  // abort frees the bus
        end
        else
        begin
            start_q <= ~filt_i.cur.sda &  filt_i.prev.sda & filt_i.cur.scl;  // SDA fall, SCL high
            stop_q  <=  filt_i.cur.sda & ~filt_i.prev.sda & filt_i.cur.scl;  // SDA rise, SCL high
            busy_o  <= (start_q | busy_o) & ~stop_q;
        end
    end

    // read data, kept across software reset
    always_ff @(posedge clk_i or negedge rstn_i)
    begin
        if (!rstn_i)
            dout_o <= 1'b1;
        else if (scl_rise)
            dout_o <= filt_i.cur.sda;
    end

endmodule

`default_nettype wire

//--- source/i2c_phase_timer.sv
`timescale 1ns/1ns
`default_nettype none

module i2c_phase_timer
    import i2c_bus_pkg::*;
(
    input  logic                  clk_i,         // system clock
    input  logic                  rstn_i,        // async reset, active low
    input  logic                  sw_rst_i,      // software abort
    input  logic [PRESCALE_W-1:0] clk_cnt_i,     // prescale value
    input  logic                  scl_oen_i,     // master SCL enable
    input  logic                  scl_filt_i,    // filtered SCL level
    output logic                  phase_tick_o   // one pulse per bus phase
);

    logic [PRESCALE_W-1:0] cnt_q;         // prescale down counter
    logic                  scl_oen_d;     // scl_oen_i one cycle back
    logic                  slave_wait_q;  // slave holds SCL low
    logic                  released;

    assign released     = scl_oen_i & ~scl_oen_d;  // master just let go of SCL
    assign phase_tick_o = (cnt_q == '0);           // tick in the reload cycle

    always_ff @(posedge clk_i or negedge rstn_i)
    begin
        if (!rstn_i)
        begin
            scl_oen_d    <= 1'b1;
            slave_wait_q <= 1'b0;
        end
        else if (sw_rst_i)
        begin
            scl_oen_d    <= 1'b1;
            slave_wait_q <= 1'b0;
        end
        else
        begin
            scl_oen_d    <= scl_oen_i;
            slave_wait_q <= (released | slave_wait_q) & ~scl_filt_i;  // lasts until SCL high
        end
    end

    always_ff @(posedge clk_i or negedge rstn_i)
    begin
        if (!rstn_i)
            cnt_q <= '0;
        else if (sw_rst_i)
            cnt_q <= '0;
        else if (phase_tick_o)
            cnt_q <= clk_cnt_i;       // reload
        else if (!slave_wait_q)
            cnt_q <= cnt_q - 1'b1;    // frozen while stretched
    end

endmodule

`default_nettype wire

//--- source/i2c_bit_sequencer.sv
`timescale 1ns/1ns
`default_nettype none

module i2c_bit_sequencer
    import i2c_bus_pkg::*;
(
    input  logic       clk_i,         // system clock
    input  logic       rstn_i,        // async reset, active low
    input  logic       sw_rst_i,      // software abort
    input  bus_cmd_e   cmd_i,         // bus command
    input  logic       cmd_valid_i,   // command strobe, sampled when idle
    input  logic       din_i,         // write bit
    input  logic       phase_tick_i,  // phase advance from timer
    output line_pair_t oen_o,         // line enables, 1 = released
    output logic       cmd_ack_o      // command done, one cycle
);

    logic       active_q;   // command in progress
    bus_cmd_e   cmd_q;      // latched command
    phase_t     phase_q;    // current phase
    logic       cmd_legal;
    logic       last_tick;
    line_pair_t next_oen;

    // the spare encodings never start a command
    always_comb
    begin
        case (cmd_i)
            CMD_START, CMD_STOP, CMD_WRITE, CMD_READ, CMD_WAIT: cmd_legal = 1'b1;
            default:                                            cmd_legal = 1'b0;
        endcase
    end

    assign last_tick = active_q & phase_tick_i & (phase_q == 2'd3);
    assign next_oen  = phase_levels(cmd_q, phase_q, oen_o.scl, din_i);  // table lookup

    // command and phase control
    always_ff @(posedge clk_i or negedge rstn_i)
    begin
        if (!rstn_i)
        begin
            active_q <= 1'b0;
            cmd_q    <= CMD_WAIT;
            phase_q  <= '0;
        end
        else if (sw_rst_i)
        begin
            active_q <= 1'b0;  // abort, back to idle
            phase_q  <= '0;
        end
        else if (!active_q)
        begin
            if (cmd_valid_i && cmd_legal)
            begin
                active_q <= 1'b1;
                cmd_q    <= cmd_i;
                phase_q  <= '0;  // start in phase 0
            end
        end
        else if (phase_tick_i)
        begin
            phase_q <= phase_q + 1'b1;  // wraps to 0 after phase 3
            if (phase_q == 2'd3)
                active_q <= 1'b0;
        end
    end

    // line enables lag the phase by one edge
    always_ff @(posedge clk_i or negedge rstn_i)
    begin
        if (!rstn_i)
            oen_o <= '1;
        else if (sw_rst_i)
            oen_o <= '1;  // release both lines
        else if (active_q)
            oen_o <= next_oen;
    end

    // acknowledge on the last tick
    always_ff @(posedge clk_i or negedge rstn_i)
    begin
        if (!rstn_i)
            cmd_ack_o <= 1'b0;
        else if (sw_rst_i)
            cmd_ack_o <= 1'b0;
        else
            cmd_ack_o <= last_tick;
    end

endmodule

`default_nettype wire

//--- source/i2c_bus_ctrl.sv
`timescale 1ns/1ns
`default_nettype none

module i2c_bus_ctrl
    import i2c_bus_pkg::*;
(
    input  logic                  clk_i,        // system clock
    input  logic                  rstn_i,       // async reset, active low
    input  logic                  sw_rst_i,     // aborts the transfer
    input  logic [PRESCALE_W-1:0] clk_cnt_i,    // prescale, one phase per period
    input  bus_cmd_e              cmd_i,        // bus command
    input  logic                  cmd_valid_i,  // command strobe
    input  logic                  din_i,        // write bit
    input  logic                  scl_i,        // SCL line level
    input  logic                  sda_i,        // SDA line level
    output logic                  cmd_ack_o,    // command done
    output logic                  busy_o,       // bus busy
    output logic                  dout_o,       // read bit
    output logic                  scl_oen_o,    // SCL enable, 0 pulls low
    output logic                  sda_oen_o     // SDA enable, 0 pulls low
);

    line_pair_t  lines;       // raw bus
    filt_lines_t filt;        // filtered bus
    line_pair_t  oen;         // master enables
    logic        phase_tick;

    assign lines.scl = scl_i;
    assign lines.sda = sda_i;
    assign scl_oen_o = oen.scl;
    assign sda_oen_o = oen.sda;

    i2c_line_filter u_filter (
        .clk_i     (clk_i),
        .rstn_i    (rstn_i),
        .sw_rst_i  (sw_rst_i),
        .clk_cnt_i (clk_cnt_i),
        .lines_i   (lines),
        .filt_o    (filt)
    );

    i2c_bus_monitor u_monitor (
        .clk_i    (clk_i),
        .rstn_i   (rstn_i),
        .sw_rst_i (sw_rst_i),
        .filt_i   (filt),
        .busy_o   (busy_o),
        .dout_o   (dout_o)
    );

    i2c_phase_timer u_timer (
        .clk_i        (clk_i),
        .rstn_i       (rstn_i),
        .sw_rst_i     (sw_rst_i),
        .clk_cnt_i    (clk_cnt_i),
        .scl_oen_i    (oen.scl),
        .scl_filt_i   (filt.cur.scl),  // stretch seen on filtered SCL
        .phase_tick_o (phase_tick)
    );

    i2c_bit_sequencer u_sequencer (
        .clk_i        (clk_i),
        .rstn_i       (rstn_i),
        .sw_rst_i     (sw_rst_i),
        .cmd_i        (cmd_i),
        .cmd_valid_i  (cmd_valid_i),
        .din_i        (din_i),
        .phase_tick_i (phase_tick),
        .oen_o        (oen),
        .cmd_ack_o    (cmd_ack_o)
    );

endmodule

`default_nettype wire

//--- tests/i2c_bus_ctrl_sva.sv
`timescale 1ns/1ns
`default_nettype none

module sequencer_checks
    import i2c_bus_pkg::*;
(
    input logic       clk_i,         // sequencer clock
    input logic       rstn_i,        // async reset, active low
    input logic       sw_rst_i,      // software abort
    input logic       phase_tick_i,  // phase advance
    input line_pair_t oen_i,         // line enables
    input logic       cmd_ack_i      // command done
);

    ack_single_cycle: assert property (@(posedge clk_i) disable iff (!rstn_i)
        cmd_ack_i |=> !cmd_ack_i)
        else $error("cmd_ack_o held high for more than one cycle");

    // ack comes from the tick that closes phase 3
    ack_after_tick: assert property (@(posedge clk_i) disable iff (!rstn_i)
        cmd_ack_i |-> $past(phase_tick_i))
        else $error("cmd_ack_o rose without a phase tick before it");

    release_on_abort: assert property (@(posedge clk_i) disable iff (!rstn_i)
        sw_rst_i |=> (oen_i.scl && oen_i.sda))
        else $error("line enables not released after sw_rst_i");

endmodule

bind i2c_bit_sequencer sequencer_checks chk0 (
    .clk_i        (clk_i),
    .rstn_i       (rstn_i),
    .sw_rst_i     (sw_rst_i),
    .phase_tick_i (phase_tick_i),
    .oen_i        (oen_o),
    .cmd_ack_i    (cmd_ack_o)
);

`default_nettype wire

//--- tests/i2c_bus_ctrl_tb.sv
`timescale 1ns/1ns
`default_nettype none

module i2c_bus_ctrl_tb
    import i2c_bus_pkg::*;
();

    localparam int         PRESCALE = 15;     // one bus phase per 16 clocks
    localparam int         COLS     = 6;      // fields per command line
    localparam int         MAX_CMDS = 42;     // 42 x 6 entries fit in 256
    localparam int         ABORT_AT = 24;     // cycles into a command before abort
    localparam int         QUIET    = 80;     // ack-free window after abort
    localparam logic [7:0] NO_CHECK = 8'h02;  // expected value to skip

    logic                  clk_i;
    logic                  rstn_i;
    logic                  sw_rst_i;
    logic [PRESCALE_W-1:0] clk_cnt_i;
    bus_cmd_e              cmd_i;
    logic                  cmd_valid_i;
    logic                  din_i;
    logic                  scl_i;
    logic                  sda_i;
    logic                  cmd_ack_o;
    logic                  busy_o;
    logic                  dout_o;
    logic                  scl_oen_o;
    logic                  sda_oen_o;
    logic                  slave_hold;       // slave stretches SCL
    logic                  slave_bit;        // slave level on SDA
    logic [7:0]            vec_mem [0:255];  // command table from file
    logic                  loaded;
    int                    num_cmds;
    int                    max_stretch;
    int                    err_count;
    int                    check_count;

    // open drain wired AND
    assign scl_i = scl_oen_o & ~slave_hold;
    assign sda_i = sda_oen_o & slave_bit;

    i2c_bus_ctrl dut0 (
        .clk_i       (clk_i),
        .rstn_i      (rstn_i),
        .sw_rst_i    (sw_rst_i),
        .clk_cnt_i   (clk_cnt_i),
        .cmd_i       (cmd_i),
        .cmd_valid_i (cmd_valid_i),
        .din_i       (din_i),
        .scl_i       (scl_i),
        .sda_i       (sda_i),
        .cmd_ack_o   (cmd_ack_o),
        .busy_o      (busy_o),
        .dout_o      (dout_o),
        .scl_oen_o   (scl_oen_o),
        .sda_oen_o   (sda_oen_o)
    );

    initial
    begin
        clk_i = 1'b0;
        forever #5 clk_i = ~clk_i;  // 10 ns period
    end

    task automatic report_mismatch(input string name, input logic [7:0] got,
                                   input logic [7:0] exp);
        err_count++;
        $display("Fail %s: got 0x%h, expected 0x%h", name, got, exp);
    endtask

    task automatic report_problem(input string what);
        err_count++;
        $display("Error: %s", what);
    endtask

    // line enables left behind by phase 3 of each command
    function automatic logic [1:0] final_levels(input bus_cmd_e cmd, input logic din);
        case (cmd)
            CMD_START: return 2'b00;
            CMD_WRITE: return {1'b0, din};
            CMD_READ:  return 2'b01;
            default:   return 2'b11;  // STOP and WAIT end released
        endcase
    endfunction

    task automatic load_vectors();
        for (int i = 0; i < 256; i++)
            vec_mem[8'(i)] = 8'hff;  // unread entries mark the end
        $readmemh("tests/i2c_bus_testdata.txt", vec_mem);
        while (num_cmds < MAX_CMDS && vec_mem[8'(num_cmds * COLS)] != 8'hff)
            num_cmds++;
        for (int i = 0; i < num_cmds; i++)
            if (int'(vec_mem[8'(i * COLS + 2)]) > max_stretch)
                max_stretch = int'(vec_mem[8'(i * COLS + 2)]);
        loaded = 1'b1;
    endtask

    task automatic expect_no_ack(input int cycles);
        repeat (cycles)
        begin
            @(negedge clk_i);
            check_count++;
            if (cmd_ack_o)
                report_problem("acknowledge arrived for an aborted command");
        end
    endtask

    task automatic run_command(input int idx);
        logic [7:0] base;
        bus_cmd_e   cmd;
        logic       din;
        int         stretch;
        logic       abort;
        logic [7:0] exp_busy;
        logic [7:0] exp_dout;
        logic       prev_scl;
        int         held;
        int         high_cycles;  // cycles with SCL released by the master
        base        = 8'(idx * COLS);
        cmd         = bus_cmd_e'(vec_mem[base][2:0]);
        din         = vec_mem[base + 8'd1][0];
        stretch     = int'(vec_mem[base + 8'd2]);
        abort       = vec_mem[base + 8'd3][0];
        exp_busy    = vec_mem[base + 8'd4];
        exp_dout    = vec_mem[base + 8'd5];
        held        = 0;
        high_cycles = 0;
        @(negedge clk_i);
        cmd_i       = cmd;
        din_i       = din;
        cmd_valid_i = 1'b1;
        slave_bit   = (cmd == CMD_READ) ? din : 1'b1;  // slave answers reads only
        slave_hold  = (stretch != 0);                  // SCL is low here already
        prev_scl    = scl_oen_o;
        @(negedge clk_i);
        cmd_valid_i = 1'b0;
        if (abort)
        begin
            expect_no_ack(ABORT_AT);
            sw_rst_i   = 1'b1;
            slave_hold = 1'b0;
            slave_bit  = 1'b1;
            @(negedge clk_i);
            sw_rst_i = 1'b0;
            check_count++;
            if (!scl_oen_o || !sda_oen_o)
                report_mismatch("scl_oen_o/sda_oen_o", {6'b0, scl_oen_o, sda_oen_o}, 8'h03);
            expect_no_ack(QUIET);
            check_count++;
            if (busy_o)
                report_mismatch("busy_o", {7'b0, busy_o}, 8'h00);
        end
        else
        begin
            while (!cmd_ack_o)
            begin
                if (cmd == CMD_WRITE && scl_oen_o && !prev_scl)  // data clock rises
                begin
                    check_count++;
                    if (sda_oen_o != din)
                        report_mismatch("sda_oen_o", {7'b0, sda_oen_o}, {7'b0, din});
                end
                if (scl_oen_o)
                    high_cycles++;
                if (slave_hold && scl_oen_o)  // master let go, count the stretch
                begin
                    held++;
                    if (held >= stretch)
                        slave_hold = 1'b0;
                end
                prev_scl = scl_oen_o;
                @(negedge clk_i);
            end
            check_count++;
            if (slave_hold)
                report_problem("acknowledge arrived while the slave still held SCL low");
            if (stretch != 0)
            begin
                check_count++;
                if (high_cycles < stretch + 2 * PRESCALE)  // stretch plus phases 1 and 2
                    report_problem("SCL high phase was not extended while the slave stretched");
            end
            slave_hold = 1'b0;
            slave_bit  = 1'b1;  // SCL is low at the end of a read
            check_count++;
            if ({scl_oen_o, sda_oen_o} != final_levels(cmd, din))
                report_mismatch("scl_oen_o/sda_oen_o", {6'b0, scl_oen_o, sda_oen_o},
                                {6'b0, final_levels(cmd, din)});
            if (exp_busy != NO_CHECK)
            begin
                check_count++;
                if (busy_o != exp_busy[0])
                    report_mismatch("busy_o", {7'b0, busy_o}, exp_busy);
            end
            if (exp_dout != NO_CHECK)
            begin
                check_count++;
                if (dout_o != exp_dout[0])
                    report_mismatch("dout_o", {7'b0, dout_o}, exp_dout);
            end
        end
    endtask

    initial
    begin
        void'($urandom(84));  // seed for the command gaps
        rstn_i      = 1'b0;
        sw_rst_i    = 1'b0;
        clk_cnt_i   = PRESCALE_W'(PRESCALE);
        cmd_i       = CMD_WAIT;
        cmd_valid_i = 1'b0;
        din_i       = 1'b0;
        slave_hold  = 1'b0;
        slave_bit   = 1'b1;
        loaded      = 1'b0;
        num_cmds    = 0;
        max_stretch = 0;
        err_count   = 0;
        check_count = 0;
        load_vectors();
        repeat (2) @(negedge clk_i);
        rstn_i = 1'b1;
        repeat (4) @(negedge clk_i);  // let the filter settle
        for (int n = 0; n < num_cmds; n++)
        begin
            repeat ($urandom % 8) @(negedge clk_i);
            run_command(n);
        end
        $display("%0d commands, %0d checks, %0d errors", num_cmds, check_count, err_count);
        if (err_count == 0)
            $display("All checks passed");
        else
            $display("Checks failed");
        $finish;
    end

    // limit scales with the command count and the longest stretch
    initial
    begin
        wait (loaded);
        repeat (num_cmds * (4 * (PRESCALE + 1) + max_stretch + 64)) @(posedge clk_i);
        $display("Timeout: the command sequence did not finish in time");
        $display("Checks failed");
        $finish;
    end

endmodule

`default_nettype wire

//--- tests/i2c_bus_testdata.txt
// columns are cmd din stretch abort busy dout in hex, busy and dout checked at the ack
// cmd 1 START 2 STOP 3 WRITE 4 READ 5 WAIT, a 2 in busy or dout skips that check
01 00 00 00 02 02
03 01 00 00 01 02
03 00 00 00 01 02
04 01 00 00 01 01
04 00 00 00 01 00
04 01 05 00 01 01
04 00 20 00 01 00
03 01 00 00 01 02
02 00 00 00 02 02
05 00 00 00 00 02
01 00 00 00 02 02
03 00 00 01 02 02
05 00 00 00 00 02
01 00 00 00 02 02
04 01 0a 00 01 01
02 00 00 00 02 02
05 00 00 00 00 02

//--- verilog.f
source/i2c_bus_pkg.sv
source/i2c_line_filter.sv
source/i2c_bus_monitor.sv
source/i2c_phase_timer.sv
source/i2c_bit_sequencer.sv
source/i2c_bus_ctrl.sv
tests/i2c_bus_ctrl_sva.sv
tests/i2c_bus_ctrl_tb.sv

//--- run_sim.sh
#!/bin/sh
# builds the testbench with Verilator, runs it and checks the log

cd "$(dirname "$0")" || exit 1

TOP=i2c_bus_ctrl_tb
LOG=sim.log

verilator --binary --timing --assert --timescale 1ns/1ns \
    --top-module "$TOP" -o "$TOP" -f verilog.f
if [ $? -ne 0 ]; then
    echo "Verilator build failed"
    exit 1
fi

./obj_dir/"$TOP" > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if grep -qx "All checks passed" "$LOG"; then
    exit 0
fi
echo "pass message not found in $LOG"
exit 1
